//--- ls_unit.f
rtl/ls_pkg.sv
rtl/ls_ifs.sv
rtl/ls_addr_gen.sv
rtl/ls_ctrl.sv
rtl/ls_sq_ptrs.sv
rtl/ls_sq_ram.sv
rtl/ls_data_mem.sv
rtl/ls_load_align.sv
rtl/ls_unit.sv
verif/ls_unit_chk.sv
verif/ls_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the load-store unit testbench with Verilator.
# Exit status is nonzero unless the log holds the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module ls_unit_tb -f ls_unit.f --Mdir obj_dir -o ls_unit_sim \
    && ./obj_dir/ls_unit_sim | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }

grep -qx "ALL CHECKS PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

//--- verif/ls_unit_tb.sv
// Directed testbench for the load-store unit
// Keeps a shadow byte memory and queues of expected writebacks and
// exceptions, and checks every strobe the DUT produces against them
`default_nettype none

module ls_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import ls_pkg::*;

    localparam int CLK_NS       = 20;
    localparam int RESET_CYCLES = 10;
    // Requests issued over all tests
    localparam int NUM_REQS     = 48;
    localparam int WATCHDOG_NS  = (NUM_REQS * 20 + RESET_CYCLES) * CLK_NS;

    logic      clk = 1'b0;
    logic      rst;
    logic      issue_valid;
    ls_op_e    issue_op;
    fn3_t      issue_fn3;
    addr_t     issue_base;
    offset_t   issue_offset;
    word_t     issue_data;
    id_t       issue_id;
    logic      issue_ready;
    logic      wb_done;
    id_t       wb_id;
    word_t     wb_data;
    logic      exc_valid;
    exc_code_t exc_code;
    addr_t     exc_tval;
    id_t       exc_id;
    logic      idle;

    logic [7:0] shadow [1024];
    id_t        wb_id_q[$];
    word_t      wb_data_q[$];
    exc_code_t  exc_code_q[$];
    addr_t      exc_tval_q[$];
    id_t        exc_id_q[$];
    id_t        id_ctr;
    int         seed = 84973;
    int         n_checks;
    int         n_errors;

    ls_unit u_dut (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_fn3    (issue_fn3),
        .issue_base   (issue_base),
        .issue_offset (issue_offset),
        .issue_data   (issue_data),
        .issue_id     (issue_id),
        .issue_ready  (issue_ready),
        .wb_done      (wb_done),
        .wb_id        (wb_id),
        .wb_data      (wb_data),
        .exc_valid    (exc_valid),
        .exc_code     (exc_code),
        .exc_tval     (exc_tval),
        .exc_id       (exc_id),
        .idle         (idle)
    );

    bind ls_unit ls_unit_chk u_chk (
        .clk         (clk),
        .rst         (rst),
        .wb_done     (wb_done),
        .exc_valid   (exc_valid),
        .issue_ready (issue_ready),
        .state       (u_ctrl.state),
        .sq_push     (sq_push),
        .sq_full     (sq_full)
    );

    always #(CLK_NS / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks and error reporting
    task automatic cmp_word(input string name, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic cmp_addr(input string name, input addr_t got, input addr_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic cmp_id(input string name, input id_t got, input id_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %s got 0x%01h expected 0x%01h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic cmp_code(input string name, input exc_code_t got, input exc_code_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %s got 0x%01h expected 0x%01h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic flag_error(input string msg);
        n_errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    function automatic addr_t eff_addr(input addr_t base, input offset_t off);
        return base + {{20{off[11]}}, off};
    endfunction

    function automatic logic is_misaligned(input fn3_t fn3, input addr_t a);
        case (fn3)
            FN3_H, FN3_HU: return a[0];
            FN3_W:         return a[1:0] != 2'b00;
            default:       return 1'b0;
        endcase
    endfunction

    function automatic word_t expect_load(input fn3_t fn3, input addr_t a);
        int         i;
        logic [7:0] b;
        logic [15:0] h;
        i = int'(a[9:0]);
        b = shadow[i];
        h = {shadow[i + 1], shadow[i]};
        case (fn3)
            FN3_B:   return {{24{b[7]}}, b};
            FN3_BU:  return {24'b0, b};
            FN3_H:   return {{16{h[15]}}, h};
            FN3_HU:  return {16'b0, h};
            default: return {shadow[i + 3], shadow[i + 2], h};
        endcase
    endfunction

    task automatic shadow_store(input fn3_t fn3, input addr_t a, input word_t d);
        int i;
        int nbytes;
        i = int'(a[9:0]);
        nbytes = (fn3 == FN3_W) ? 4 : ((fn3 == FN3_H || fn3 == FN3_HU) ? 2 : 1);
        for (int k = 0; k < nbytes; k++) begin
            shadow[i + k] = d[k*8 +: 8];
        end
    endtask

    task automatic expect_exc(input exc_code_t code, input addr_t a, input id_t id);
        exc_code_q.push_back(code);
        exc_tval_q.push_back(a);
        exc_id_q.push_back(id);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Request drivers, called and returning on a falling edge
    task automatic issue_req(input ls_op_e op, input fn3_t fn3, input addr_t base,
                             input offset_t off, input word_t data, input id_t id);
        issue_valid  = 1'b1;
        issue_op     = op;
        issue_fn3    = fn3;
        issue_base   = base;
        issue_offset = off;
        issue_data   = data;
        issue_id     = id;
        while (!issue_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        issue_valid = 1'b0;
        id_ctr++;
    endtask

    task automatic load_req(input fn3_t fn3, input addr_t base, input offset_t off);
        addr_t a;
        a = eff_addr(base, off);
        if (is_misaligned(fn3, a)) begin
            expect_exc(EXC_LOAD_MISALIGNED, a, id_ctr);
        end else if (a >= addr_t'(MEM_WORDS * 4)) begin
            expect_exc(EXC_LOAD_FAULT, a, id_ctr);
        end else begin
            wb_id_q.push_back(id_ctr);
            wb_data_q.push_back(expect_load(fn3, a));
        end
        issue_req(OP_LOAD, fn3, base, off, '0, id_ctr);
    endtask

    task automatic store_req(input fn3_t fn3, input addr_t base, input offset_t off,
                             input word_t d);
        addr_t a;
        a = eff_addr(base, off);
        if (is_misaligned(fn3, a)) begin
            expect_exc(EXC_STORE_MISALIGNED, a, id_ctr);
        end else if (a >= addr_t'(MEM_WORDS * 4)) begin
            expect_exc(EXC_STORE_FAULT, a, id_ctr);
        end else begin
            shadow_store(fn3, a, d);
        end
        issue_req(OP_STORE, fn3, base, off, d, id_ctr);
    endtask

    // Strobe monitor
    always @(negedge clk) begin
        if (!rst && wb_done) begin
            if (wb_id_q.size() == 0) begin
                flag_error("writeback with no load outstanding");
            end else begin
                cmp_id("wb_id", wb_id, wb_id_q.pop_front());
                cmp_word("wb_data", wb_data, wb_data_q.pop_front());
            end
        end
        if (!rst && exc_valid) begin
            if (exc_code_q.size() == 0) begin
                flag_error("exception with no faulting request outstanding");
            end else begin
                cmp_code("exc_code", exc_code, exc_code_q.pop_front());
                cmp_addr("exc_tval", exc_tval, exc_tval_q.pop_front());
                cmp_id("exc_id", exc_id, exc_id_q.pop_front());
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    task automatic word_roundtrip;
        word_t d;
        d = $random(seed);
        // Load follows right behind the store and must wait for it
        store_req(FN3_W, 32'h30, 12'h010, d);
        load_req(FN3_W, 32'h40, 12'h000);
    endtask

    task automatic subword_lanes;
        word_t d;
        for (int lane = 0; lane < 4; lane++) begin
            d = $random(seed);
            d[7] = lane[0];
            store_req(FN3_B, 32'h80, offset_t'(lane), d);
        end
        for (int lane = 0; lane < 4; lane++) begin
            load_req(FN3_B, 32'h80, offset_t'(lane));
            load_req(FN3_BU, 32'h80, offset_t'(lane));
        end
        // Negative offsets reach 0x90 and 0x92
        for (int k = 0; k < 2; k++) begin
            d = $random(seed);
            d[15] = ~k[0];
            store_req(FN3_H, 32'hA0, offset_t'(12'hFF0 + 2 * k), d);
        end
        for (int k = 0; k < 2; k++) begin
            load_req(FN3_H, 32'h90, offset_t'(2 * k));
            load_req(FN3_HU, 32'h90, offset_t'(2 * k));
        end
    endtask

    task automatic load_latency;
        while (!idle) begin
            @(negedge clk);
        end
        load_req(FN3_W, 32'h40, 12'h000);
        for (int k = 0; k < 4; k++) begin
            if (k > 0) begin
                @(negedge clk);
            end
            if (wb_done !== (k == 2)) begin
                flag_error($sformatf("wb_done is %b %0d cycles after load acceptance",
                                     wb_done, k));
            end
        end
    endtask

    task automatic bad_address;
        store_req(FN3_W, 32'h100, 12'h000, $random(seed));
        load_req(FN3_H, 32'h100, 12'h001);
        if (exc_valid !== 1'b0) begin
            flag_error("exception strobe in the cycle after acceptance");
        end
        @(negedge clk);
        if (exc_valid !== 1'b1) begin
            flag_error("no exception strobe two cycles after acceptance");
        end
        load_req(FN3_W, 32'h100, 12'h002);
        store_req(FN3_H, 32'h100, 12'h003, $random(seed));
        store_req(FN3_W, 32'h100, 12'h001, $random(seed));
        load_req(FN3_W, 32'h3F0, 12'h010);
        // Out of range stores whose low address bits alias real words
        store_req(FN3_W, 32'h500, 12'h000, $random(seed));
        store_req(FN3_B, 32'h3FF, 12'h002, $random(seed));
        load_req(FN3_W, 32'h0, 12'hFFC);
        load_req(FN3_W, 32'h100, 12'h000);
    endtask

    task automatic burst_fence;
        for (int i = 0; i < 8; i++) begin
            store_req(FN3_W, 32'h200, offset_t'(i * 4), $random(seed));
        end
        issue_req(OP_FENCE, FN3_W, '0, '0, '0, id_ctr);
        while (!issue_ready) begin
            @(negedge clk);
        end
        if (idle !== 1'b1) begin
            flag_error("idle low after the fence completed");
        end
        for (int i = 0; i < 8; i++) begin
            load_req(FN3_W, 32'h200, offset_t'(i * 4));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        rst          = 1'b1;
        issue_valid  = 1'b0;
        issue_op     = OP_LOAD;
        issue_fn3    = FN3_W;
        issue_base   = '0;
        issue_offset = '0;
        issue_data   = '0;
        issue_id     = '0;
        id_ctr       = '0;
        n_checks     = 0;
        n_errors     = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        word_roundtrip();
        subword_lanes();
        load_latency();
        bad_address();
        burst_fence();

        while (wb_id_q.size() != 0 || exc_code_q.size() != 0 || !idle) begin
            @(negedge clk);
        end
        // Catch any stray strobe
        repeat (5) @(negedge clk);

        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/ls_unit_chk.sv
// Protocol assertions for the load-store unit
// Bound into ls_unit by the testbench
`default_nettype none

module ls_unit_chk (
    input wire logic                clk,
    input wire logic                rst,
    input wire logic                wb_done,
    input wire logic                exc_valid,
    input wire logic                issue_ready,
    input wire ls_pkg::ctrl_state_e state,
    input wire logic                sq_push,
    input wire logic                sq_full
);
    timeunit 1ns;
    timeprecision 1ps;
    import ls_pkg::*;

    // A request ends either in a writeback or in an exception
    a_strobes_apart: assert property (@(posedge clk) disable iff (rst)
        !(wb_done && exc_valid))
        else $error("writeback and exception strobes in the same cycle");

    a_ready_in_run: assert property (@(posedge clk) disable iff (rst)
        (state != ST_RUN) |-> !issue_ready)
        else $error("issue_ready high outside the run state");

    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        sq_full |-> !sq_push)
        else $error("store queue push while full");

endmodule

`default_nettype wire

//--- rtl/ls_unit.sv
// Top level of the load-store unit
// Requests come in on the issue strobe, results leave as writeback or
// exception strobes, idle reports that nothing is buffered or in flight
`default_nettype none

module ls_unit (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            issue_valid,
    input  wire ls_pkg::ls_op_e  issue_op,
    input  wire ls_pkg::fn3_t    issue_fn3,
    input  wire ls_pkg::addr_t   issue_base,
    input  wire ls_pkg::offset_t issue_offset,
    input  wire ls_pkg::word_t   issue_data,
    input  wire ls_pkg::id_t     issue_id,
    output logic                 issue_ready,
    output logic                 wb_done,
    output ls_pkg::id_t          wb_id,
    output ls_pkg::word_t        wb_data,
    output logic                 exc_valid,
    output ls_pkg::exc_code_t    exc_code,
    output ls_pkg::addr_t        exc_tval,
    output ls_pkg::id_t          exc_id,
    output logic                 idle
);
    import ls_pkg::*;

    ls_req_if req_if ();
    ls_mem_if mem_if ();

    logic                 req_hold;
    logic                 sq_push;
    logic                 sq_pop;
    logic                 sq_full;
    logic                 sq_empty;
    logic                 load_issue;
    logic                 load_inflight;
    logic [SQ_PTR_W-1:0]  wr_ptr;
    logic [SQ_PTR_W-1:0]  rd_ptr;
    logic [MEM_IDX_W-1:0] head_idx;
    be_t                  head_be;
    word_t                head_data;

    ls_addr_gen u_addr_gen (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_op     (issue_op),
        .issue_fn3    (issue_fn3),
        .issue_base   (issue_base),
        .issue_offset (issue_offset),
        .issue_data   (issue_data),
        .issue_id     (issue_id),
        .req_hold     (req_hold),
        .req          (req_if.src)
    );

    ls_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .sq_full       (sq_full),
        .sq_empty      (sq_empty),
        .load_inflight (load_inflight),
        .head_idx      (head_idx),
        .head_be       (head_be),
        .head_data     (head_data),
        .req           (req_if.dst),
        .mem           (mem_if.ctrl),
        .issue_ready   (issue_ready),
        .req_hold      (req_hold),
        .sq_push       (sq_push),
        .sq_pop        (sq_pop),
        .load_issue    (load_issue),
        .exc_valid     (exc_valid),
        .exc_code      (exc_code),
        .exc_tval      (exc_tval),
        .exc_id        (exc_id),
        .idle          (idle)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Store queue
    ls_sq_ptrs u_sq_ptrs (
        .clk      (clk),
        .rst      (rst),
        .sq_push  (sq_push),
        .sq_pop   (sq_pop),
        .wr_ptr   (wr_ptr),
        .rd_ptr   (rd_ptr),
        .sq_full  (sq_full),
        .sq_empty (sq_empty)
    );

    ls_sq_ram u_sq_ram (
        .clk       (clk),
        .wr_ptr    (wr_ptr),
        .rd_ptr    (rd_ptr),
        .sq_push   (sq_push),
        .req       (req_if.dst),
        .head_idx  (head_idx),
        .head_be   (head_be),
        .head_data (head_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memory and load return
    ls_data_mem u_data_mem (
        .clk (clk),
        .mem (mem_if.mem)
    );

    ls_load_align u_load_align (
        .clk           (clk),
        .rst           (rst),
        .load_issue    (load_issue),
        .rdata         (mem_if.rdata),
        .req           (req_if.dst),
        .load_inflight (load_inflight),
        .wb_done       (wb_done),
        .wb_id         (wb_id),
        .wb_data       (wb_data)
    );

endmodule

`default_nettype wire

//--- rtl/ls_load_align.sv
// Load return path
// Keeps the attributes of the issued load, then picks the byte or half
// out of the memory word and extends it into the writeback register
`default_nettype none

module ls_load_align (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           load_issue,
    input  wire ls_pkg::word_t  rdata,
    ls_req_if.dst               req,
    output logic                load_inflight,
    output logic                wb_done,
    output ls_pkg::id_t         wb_id,
    output ls_pkg::word_t       wb_data
);
    import ls_pkg::*;

    logic [1:0]  off_q;
    fn3_t        fn3_q;
    id_t         id_q;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    word_t       ext_data;

    // Attributes of the load now at the memory
    always_ff @(posedge clk) begin
        if (load_issue) begin
            off_q <= req.addr[1:0];
            fn3_q <= req.fn3;
            id_q  <= req.id;
        end
    end

    // Accesses are aligned here, a half never straddles the word middle
    assign byte_sel = rdata[{off_q, 3'b000} +: 8];
    assign half_sel = off_q[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (fn3_q)
            FN3_B:   ext_data = {{24{byte_sel[7]}}, byte_sel};
            FN3_BU:  ext_data = {24'b0, byte_sel};
            FN3_H:   ext_data = {{16{half_sel[15]}}, half_sel};
            FN3_HU:  ext_data = {16'b0, half_sel};
            default: ext_data = rdata;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Writeback
    always_ff @(posedge clk) begin
        if (rst) begin
            load_inflight <= 1'b0;
            wb_done       <= 1'b0;
        end else begin
            load_inflight <= load_issue;
            wb_done       <= load_inflight;
        end
    end

    always_ff @(posedge clk) begin
        if (load_inflight) begin
            wb_id   <= id_q;
            wb_data <= ext_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/ls_data_mem.sv
// Local data memory of the load-store unit
// Byte-enable writes, read data registered one cycle after the request
`default_nettype none

module ls_data_mem (
    input  wire logic clk,
    ls_mem_if.mem     mem
);
    import ls_pkg::*;

    word_t ram [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (mem.en) begin
            if (mem.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem.be[b]) begin
                        ram[mem.idx][b*8 +: 8] <= mem.wdata[b*8 +: 8];
                    end
                end
            end else begin
                mem.rdata <= ram[mem.idx];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/ls_sq_ram.sv
// Store queue entries
// Written from the issue register, head read out combinationally
`default_nettype none

module ls_sq_ram (
    input  wire logic                         clk,
    input  wire logic [ls_pkg::SQ_PTR_W-1:0]  wr_ptr,
    input  wire logic [ls_pkg::SQ_PTR_W-1:0]  rd_ptr,
    input  wire logic                         sq_push,
    ls_req_if.dst                             req,
    output logic [ls_pkg::MEM_IDX_W-1:0]      head_idx,
    output ls_pkg::be_t                       head_be,
    output ls_pkg::word_t                     head_data
);
    import ls_pkg::*;

    logic [MEM_IDX_W-1:0] idx_q  [SQ_DEPTH];
    be_t                  be_q   [SQ_DEPTH];
    word_t                data_q [SQ_DEPTH];

    always_ff @(posedge clk) begin
        if (sq_push) begin
            idx_q[wr_ptr] <= req.addr[MEM_IDX_W+1:2];
            be_q[wr_ptr]  <= req.be;
            // Data moved onto the lanes its byte enables select
            data_q[wr_ptr] <= req.data << {req.addr[1:0], 3'b000};
        end
    end

    assign head_idx  = idx_q[rd_ptr];
    assign head_be   = be_q[rd_ptr];
    assign head_data = data_q[rd_ptr];

endmodule

`default_nettype wire

//--- rtl/ls_sq_ptrs.sv
// Store queue bookkeeping
// Read and write pointers plus an occupancy count
`default_nettype none

module ls_sq_ptrs (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        sq_push,
    input  wire logic                        sq_pop,
    output logic [ls_pkg::SQ_PTR_W-1:0]      wr_ptr,
    output logic [ls_pkg::SQ_PTR_W-1:0]      rd_ptr,
    output logic                             sq_full,
    output logic                             sq_empty
);
    import ls_pkg::*;

    // Extra bit so all SQ_DEPTH entries can be counted
    logic [SQ_PTR_W:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (sq_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (sq_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({sq_push, sq_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign sq_empty = (count == '0);
    assign sq_full  = (count >= (SQ_PTR_W + 1)'(SQ_DEPTH - 1));

endmodule

`default_nettype wire

//--- rtl/ls_ctrl.sv
// Control of the load-store unit
// Decides issue, load ordering behind queued stores and fence stalls,
// owns the memory port and registers exceptions
`default_nettype none

module ls_ctrl (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         sq_full,
    input  wire logic                         sq_empty,
    input  wire logic                         load_inflight,
    input  wire logic [ls_pkg::MEM_IDX_W-1:0] head_idx,
    input  wire ls_pkg::be_t                  head_be,
    input  wire ls_pkg::word_t                head_data,
    ls_req_if.dst                             req,
    ls_mem_if.ctrl                            mem,
    output logic                              issue_ready,
    output logic                              req_hold,
    output logic                              sq_push,
    output logic                              sq_pop,
    output logic                              load_issue,
    output logic                              exc_valid,
    output ls_pkg::exc_code_t                 exc_code,
    output ls_pkg::addr_t                     exc_tval,
    output ls_pkg::id_t                       exc_id,
    output logic                              idle
);
    import ls_pkg::*;

    ctrl_state_e state;
    logic        is_load;
    logic        is_store;
    logic        is_fence;
    logic        bad_addr;
    logic        load_go;

    assign is_load  = req.valid & (req.op == OP_LOAD);
    assign is_store = req.valid & (req.op == OP_STORE);
    assign is_fence = req.valid & (req.op == OP_FENCE);
    assign bad_addr = req.misaligned | req.fault;

    ////////////////////////////////////////////////////////////////////////////
    // Request disposal and port arbitration
    // Loads go only behind an empty queue, so they never pass a store
    assign load_go    = is_load & ~bad_addr & sq_empty;
    assign req_hold   = is_load & ~bad_addr & ~sq_empty;
    assign sq_push    = is_store & ~bad_addr;
    assign sq_pop     = ~sq_empty & ~load_go;
    assign load_issue = load_go;

    assign mem.en    = load_go | sq_pop;
    assign mem.we    = sq_pop;
    assign mem.be    = head_be;
    assign mem.idx   = load_go ? req.addr[MEM_IDX_W+1:2] : head_idx;
    assign mem.wdata = head_data;

    assign idle = sq_empty & ~req.valid & ~load_inflight;

    // One slot stays free for a store already in the issue register
    assign issue_ready = (state == ST_RUN) & ~is_load & ~is_fence & ~sq_full;

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    // Reset lands behind a fence so issue stays closed until things settle
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_FENCE_WAIT;
        end else begin
            case (state)
                ST_RUN: begin
                    if (req_hold) begin
                        state <= ST_LOAD_WAIT;
                    end else if (is_fence) begin
                        state <= ST_FENCE_WAIT;
                    end
                end
                ST_LOAD_WAIT: begin
                    if (load_go) begin
                        state <= ST_RUN;
                    end
                end
                ST_FENCE_WAIT: begin
                    if (idle) begin
                        state <= ST_RUN;
                    end
                end
                default: begin
                    state <= ST_RUN;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Exceptions
    always_ff @(posedge clk) begin
        if (rst) begin
            exc_valid <= 1'b0;
        end else begin
            exc_valid <= (is_load | is_store) & bad_addr;
        end
    end

    // Misalignment outranks the access fault
    always_ff @(posedge clk) begin
        if (req.valid & bad_addr) begin
            exc_tval <= req.addr;
            exc_id   <= req.id;
            if (req.misaligned) begin
                exc_code <= is_load ? EXC_LOAD_MISALIGNED : EXC_STORE_MISALIGNED;
            end else begin
                exc_code <= is_load ? EXC_LOAD_FAULT : EXC_STORE_FAULT;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/ls_addr_gen.sv
// Issue stage of the load-store unit
// Registers each accepted request with its effective address and
// derives the alignment check, range check and byte enables from it
`default_nettype none

module ls_addr_gen (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            issue_valid,
    input  wire logic            issue_ready,
    input  wire ls_pkg::ls_op_e  issue_op,
    input  wire ls_pkg::fn3_t    issue_fn3,
    input  wire ls_pkg::addr_t   issue_base,
    input  wire ls_pkg::offset_t issue_offset,
    input  wire ls_pkg::word_t   issue_data,
    input  wire ls_pkg::id_t     issue_id,
    input  wire logic            req_hold,
    ls_req_if.src                req
);
    import ls_pkg::*;

    logic  accept;
    addr_t eff_addr;

    assign accept   = issue_valid & issue_ready;
    assign eff_addr = issue_base + {{20{issue_offset[11]}}, issue_offset};

    // A waiting load keeps valid up until the controller lets it go
    always_ff @(posedge clk) begin
        if (rst) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= accept | req_hold;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req.op   <= issue_op;
            req.addr <= eff_addr;
            req.data <= issue_data;
            req.fn3  <= issue_fn3;
            req.id   <= issue_id;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks on the registered address
    always_comb begin
        case (req.fn3)
            FN3_H, FN3_HU: req.misaligned = req.addr[0];
            FN3_W:         req.misaligned = |req.addr[1:0];
            default:       req.misaligned = 1'b0;
        endcase
    end

    // Anything past the end of local memory has no target
    assign req.fault = req.addr >= addr_t'(MEM_WORDS * 4);

    // Byte enables for stores
    always_comb begin
        case (req.fn3)
            FN3_B, FN3_BU: req.be = be_t'(1) << req.addr[1:0];
            FN3_H, FN3_HU: req.be = req.addr[1] ? 4'b1100 : 4'b0011;
            default:       req.be = 4'b1111;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/ls_ifs.sv
// Interfaces used inside the load-store unit
// ls_req_if carries the registered request to its readers
// ls_mem_if is the single port of the local data memory
`default_nettype none

interface ls_req_if;
    import ls_pkg::*;

    logic   valid;
    ls_op_e op;
    addr_t  addr;
    be_t    be;
    word_t  data;
    fn3_t   fn3;
    id_t    id;
    logic   misaligned;
    logic   fault;

    modport src (
        output valid, op, addr, be, data, fn3, id, misaligned, fault
    );

    modport dst (
        input valid, op, addr, be, data, fn3, id, misaligned, fault
    );
endinterface

interface ls_mem_if;
    import ls_pkg::*;

    logic                 en;
    logic                 we;
    be_t                  be;
    logic [MEM_IDX_W-1:0] idx;
    word_t                wdata;
    word_t                rdata;

    // Read data comes back on the edge after en
    modport ctrl (
        output en, we, be, idx, wdata,
        input  rdata
    );

    modport mem (
        input  en, we, be, idx, wdata,
        output rdata
    );
endinterface

`default_nettype wire

//--- rtl/ls_pkg.sv
// Shared types, codes and sizes for the load-store unit
// Each RTL block imports this package where it needs a definition
`default_nettype none

package ls_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Data path types
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [11:0] offset_t;
    typedef logic [3:0]  be_t;
    typedef logic [2:0]  fn3_t;
    typedef logic [3:0]  id_t;
    typedef logic [3:0]  exc_code_t;

    ////////////////////////////////////////////////////////////////////////////
    // Width codes as found in the RISC-V fn3 field
    localparam fn3_t FN3_B  = 3'd0;
    localparam fn3_t FN3_H  = 3'd1;
    localparam fn3_t FN3_W  = 3'd2;
    localparam fn3_t FN3_BU = 3'd4;
    localparam fn3_t FN3_HU = 3'd5;

    // Exception causes as in mcause
    localparam exc_code_t EXC_LOAD_MISALIGNED  = 4'd4;
    localparam exc_code_t EXC_LOAD_FAULT       = 4'd5;
    localparam exc_code_t EXC_STORE_MISALIGNED = 4'd6;
    localparam exc_code_t EXC_STORE_FAULT      = 4'd7;

    typedef enum logic [1:0] {
        OP_LOAD,
        OP_STORE,
        OP_FENCE
    } ls_op_e;

    typedef enum logic [1:0] {
        ST_RUN,
        ST_LOAD_WAIT,
        ST_FENCE_WAIT
    } ctrl_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes
    // Local memory of 1 KiB
    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_W = 8;

    localparam int SQ_DEPTH = 4;
    localparam int SQ_PTR_W = 2;

endpackage

`default_nettype wire
